// ==== Makefile ====
# Verilator build and run for the execute core testbench

VERILATOR ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS ?= --binary --timing -Wno-fatal -j 0
TOP ?= cpu_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
source/cpu_pkg.sv
source/cpu_instr_rx.sv
source/cpu_id.sv
source/cpu_regfile.sv
source/cpu_ex.sv
source/cpu_result_tx.sv
source/cpu_core.sv
dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
// ####################
// cpu_tb
// directed testbench for the execute core: an instruction source, a result
// sink that can stall, a register model and per-field compare tasks
// ####################
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	typedef struct packed {
		logic wen;
		reg_addr_t waddr;
		word_t wdata;
		logic taken;
		word_t target;
	} rec_t;

	localparam int queue_depth = 4;
	localparam int hs_limit = 400;
	// alu 38, forwarding 16, branch 12, register zero 7, back-pressure 12
	localparam int total_instr = 38 + 16 + 12 + 7 + 12;

	logic clk;
	logic rst;
	logic in_req;
	instr_t in_instr;
	word_t in_pc;
	logic in_ack;
	logic res_req;
	logic res_ack;
	logic res_wen;
	reg_addr_t res_waddr;
	word_t res_wdata;
	logic res_taken;
	word_t res_target;

	integer seed;
	word_t mregs [32];
	word_t pc_cur;
	rec_t exp_q [$];
	rec_t got_q [$];
	logic sink_hold;
	int sink_delay;
	string cur_test;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int sent_count = 0;
	int ack_count = 0;
	logic ack_prev = 1'b0;

	cpu_core #(.queue_depth(queue_depth)) dut_i (
		.clk(clk), .rst(rst),
		.in_req(in_req), .in_instr(in_instr), .in_pc(in_pc), .in_ack(in_ack),
		.res_req(res_req), .res_ack(res_ack), .res_wen(res_wen),
		.res_waddr(res_waddr), .res_wdata(res_wdata),
		.res_taken(res_taken), .res_target(res_target)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic instr_t rtype(input logic [5:0] funct, input reg_addr_t rs,
			input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] shamt);
		instr_t ins;
		ins.r.op = op_special;
		ins.r.rs = rs;
		ins.r.rt = rt;
		ins.r.rd = rd;
		ins.r.shamt = shamt;
		ins.r.funct = funct;
		return ins;
	endfunction

	function automatic instr_t itype(input logic [5:0] op, input reg_addr_t rs,
			input reg_addr_t rt, input logic [15:0] imm);
		instr_t ins;
		ins.i.op = op;
		ins.i.rs = rs;
		ins.i.rt = rt;
		ins.i.imm = imm;
		return ins;
	endfunction

	function automatic instr_t jtype(input logic [5:0] op, input logic [25:0] target);
		instr_t ins;
		ins.j.op = op;
		ins.j.target = target;
		return ins;
	endfunction

	// architectural result of one instruction, applied to the model registers in order
	task automatic model_step(input instr_t ins, input word_t pc, output rec_t r);
		word_t a;
		word_t b;
		word_t sext;
		word_t zext;
		word_t pc4;
		word_t v;
		reg_addr_t dest;
		logic wr;
		a = mregs[ins.r.rs];
		b = mregs[ins.r.rt];
		sext = {{16{ins.i.imm[15]}}, ins.i.imm};
		zext = {16'h0000, ins.i.imm};
		pc4 = pc + 32'd4;
		v = '0;
		dest = ins.i.rt;
		wr = 1'b1;
		r = '0;
		case (ins.r.op)
			op_special: begin
				dest = ins.r.rd;
				case (ins.r.funct)
					fn_addu: v = a + b;
					fn_subu: v = a - b;
					fn_and: v = a & b;
					fn_or: v = a | b;
					fn_nor: v = ~(a | b);
					fn_slt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fn_sltu: v = (a < b) ? 32'd1 : 32'd0;
					fn_sll: v = b << ins.r.shamt;
					fn_srl: v = b >> ins.r.shamt;
					fn_jr: begin
						wr = 1'b0;
						r.taken = 1'b1;
						r.target = a;
					end
					default: wr = 1'b0;
				endcase
			end
			op_addiu: v = a + sext;
			op_andi: v = a & zext;
			op_ori: v = a | zext;
			op_slti: v = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			op_sltiu: v = (a < sext) ? 32'd1 : 32'd0;
			op_lui: v = {ins.i.imm, 16'h0000};
			op_beq, op_bne: begin
				wr = 1'b0;
				r.taken = (ins.r.op == op_beq) ? (a == b) : (a != b);
				if (r.taken)
					r.target = pc4 + {sext[29:0], 2'b00};
			end
			op_j, op_jal: begin
				r.taken = 1'b1;
				r.target = {pc4[31:28], ins.j.target, 2'b00};
				wr = (ins.r.op == op_jal);
				dest = 5'd31;
				v = pc + 32'd8;
			end
			default: wr = 1'b0;
		endcase
		r.wen = wr && (dest != 5'd0);
		r.waddr = dest;
		r.wdata = v;
		if (r.wen)
			mregs[dest] = v;
	endtask

	task automatic check_word(input string field, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			$display("mismatch %s %s: expected %h, actual %h", cur_test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg(input string field, input reg_addr_t exp, input reg_addr_t act);
		checks++;
		if (act !== exp) begin
			$display("mismatch %s %s: expected %0d, actual %0d", cur_test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string field, input bit exp, input bit act);
		checks++;
		if (act !== exp) begin
			$display("mismatch %s %s: expected %b, actual %b", cur_test, field, exp, act);
			errors++;
		end
	endtask

	// one four-phase input handshake, pc advances by one word per instruction
	task automatic send(input instr_t ins);
		rec_t r;
		int waited;
		model_step(ins, pc_cur, r);
		exp_q.push_back(r);
		@(posedge clk);
		in_instr <= ins;
		in_pc <= pc_cur;
		in_req <= 1'b1;
		pc_cur = pc_cur + 32'd4;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!in_ack && waited < hs_limit);
		if (!in_ack) begin
			$display("test %s: instruction %h was not acknowledged within %0d cycles",
					cur_test, ins, hs_limit);
			errors++;
		end else begin
			sent_count++;
		end
		in_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (in_ack && waited < hs_limit);
	endtask

	// the low half is sign extended by addiu, which the model follows
	task automatic load_reg(input reg_addr_t rd, input word_t value);
		send(itype(op_lui, 5'd0, rd, value[31:16]));
		send(itype(op_addiu, rd, rd, value[15:0]));
	endtask

	task automatic wait_records(input int n);
		int waited;
		waited = 0;
		while (got_q.size() < n && waited < n * 40) begin
			@(posedge clk);
			waited++;
		end
		if (got_q.size() < n) begin
			$display("test %s: result records missing, expected %0d but received %0d",
					cur_test, n, got_q.size());
			errors++;
		end
	endtask

	task automatic compare_records();
		rec_t e;
		rec_t g;
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			check_flag("res_taken", e.taken, g.taken);
			check_word("res_target", e.target, g.target);
			check_flag("res_wen", e.wen, g.wen);
			if (e.wen) begin
				check_reg("res_waddr", e.waddr, g.waddr);
				check_word("res_wdata", e.wdata, g.wdata);
			end
		end
		exp_q.delete();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_mark = errors;
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic end_test(input int idle);
		int n;
		wait_records(exp_q.size());
		n = exp_q.size();
		compare_records();
		repeat (idle) @(posedge clk);
		if (got_q.size() != 0) begin
			$display("test %s: %0d records arrived beyond the expected ones",
					cur_test, got_q.size());
			errors++;
			got_q.delete();
		end
		if (ack_count != sent_count) begin
			$display("test %s: %0d inputs were sent but in_ack rose %0d times",
					cur_test, sent_count, ack_count);
			errors++;
		end
		$display("test %s: %0d records, %0d errors", cur_test, n, errors - err_mark);
	endtask

	task automatic test_alu();
		logic [15:0] imm;
		logic [4:0] sh;
		begin_test("alu");
		pc_cur = 32'h0000_1000;
		for (int round = 0; round < 2; round++) begin
			imm = 16'($random(seed));
			// first round uses a negative immediate, second a positive one
			imm[15] = (round == 0);
			sh = 5'($random(seed));
			load_reg(5'd1, $random(seed));
			load_reg(5'd2, $random(seed));
			send(rtype(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0));
			send(rtype(fn_subu, 5'd1, 5'd2, 5'd4, 5'd0));
			send(rtype(fn_and, 5'd1, 5'd2, 5'd5, 5'd0));
			send(rtype(fn_or, 5'd1, 5'd2, 5'd6, 5'd0));
			send(rtype(fn_nor, 5'd1, 5'd2, 5'd7, 5'd0));
			send(rtype(fn_slt, 5'd1, 5'd2, 5'd8, 5'd0));
			send(rtype(fn_sltu, 5'd1, 5'd2, 5'd9, 5'd0));
			send(rtype(fn_sll, 5'd0, 5'd2, 5'd10, sh));
			send(rtype(fn_srl, 5'd0, 5'd2, 5'd11, sh));
			send(itype(op_addiu, 5'd1, 5'd12, imm));
			send(itype(op_andi, 5'd1, 5'd13, imm));
			send(itype(op_ori, 5'd1, 5'd14, imm));
			send(itype(op_slti, 5'd1, 5'd15, imm));
			send(itype(op_sltiu, 5'd1, 5'd16, imm));
			send(itype(op_lui, 5'd0, 5'd17, imm));
		end
		end_test(2);
	endtask

	task automatic test_forward();
		begin_test("forwarding");
		pc_cur = 32'h0000_2000;
		for (int round = 0; round < 2; round++) begin
			sink_hold <= 1'b1;
			send(itype(op_addiu, 5'd0, 5'd1, 16'($random(seed))));
			send(itype(op_addiu, 5'd0, 5'd2, 16'($random(seed))));
			send(itype(op_addiu, 5'd0, 5'd3, 16'($random(seed))));
			send(itype(op_addiu, 5'd0, 5'd4, 16'($random(seed))));
			// these four wait in the input queue until the sink lets go
			send(rtype(fn_addu, 5'd1, 5'd2, 5'd5, 5'd0));
			send(rtype(fn_subu, 5'd5, 5'd3, 5'd6, 5'd0));
			send(rtype(fn_nor, 5'd5, 5'd6, 5'd7, 5'd0));
			send(rtype(fn_sltu, 5'd7, 5'd5, 5'd8, 5'd0));
			sink_hold <= 1'b0;
			wait_records(exp_q.size());
		end
		end_test(2);
	endtask

	task automatic test_branch();
		begin_test("branch");
		pc_cur = 32'h0000_0100;
		send(itype(op_addiu, 5'd0, 5'd1, 16'd5));
		send(itype(op_addiu, 5'd0, 5'd2, 16'd5));
		send(itype(op_addiu, 5'd0, 5'd3, 16'd7));
		send(itype(op_beq, 5'd1, 5'd2, 16'h0004));
		send(itype(op_beq, 5'd1, 5'd3, 16'h0002));
		send(itype(op_bne, 5'd1, 5'd3, 16'hfffc));
		send(itype(op_bne, 5'd1, 5'd2, 16'hfff8));
		send(itype(op_beq, 5'd2, 5'd1, 16'hffff));
		// pc+4 of the jump crosses into a new 256 MB region
		pc_cur = 32'h7fff_fffc;
		send(jtype(op_j, 26'($random(seed))));
		send(jtype(op_jal, 26'($random(seed))));
		send(rtype(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
		send(rtype(fn_addu, 5'd31, 5'd0, 5'd4, 5'd0));
		end_test(2);
	endtask

	task automatic test_zero();
		begin_test("register zero");
		pc_cur = 32'h0000_3000;
		send(itype(op_addiu, 5'd0, 5'd0, 16'h1234));
		send(rtype(fn_addu, 5'd0, 5'd0, 5'd5, 5'd0));
		send(itype(op_lui, 5'd0, 5'd0, 16'hffff));
		send(itype(op_ori, 5'd0, 5'd6, 16'h0055));
		send(rtype(fn_addu, 5'd1, 5'd2, 5'd0, 5'd0));
		send(itype(op_addiu, 5'd0, 5'd7, 16'hffff));
		send(rtype(fn_sltu, 5'd0, 5'd7, 5'd8, 5'd0));
		end_test(2);
	endtask

	task automatic test_backpressure();
		begin_test("back-pressure");
		pc_cur = 32'h0000_4000;
		sink_delay <= 20;
		for (int k = 1; k <= 12; k++)
			send(itype(op_addiu, 5'(k - 1), 5'(k), 16'($random(seed))));
		end_test(30);
		sink_delay <= 0;
	endtask

	// result sink, takes one record per four-phase handshake
	initial begin
		int wait_cnt;
		rec_t r;
		res_ack = 1'b0;
		wait_cnt = 0;
		forever begin
			@(posedge clk);
			if (res_req && !res_ack && !sink_hold) begin
				if (wait_cnt < sink_delay) begin
					wait_cnt++;
				end else begin
					r = {res_wen, res_waddr, res_wdata, res_taken, res_target};
					got_q.push_back(r);
					res_ack <= 1'b1;
					wait_cnt = 0;
				end
			end else if (!res_req && res_ack) begin
				res_ack <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (in_ack && !ack_prev)
			ack_count++;
		ack_prev = in_ack;
	end

	initial begin
		repeat (total_instr * 40) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", total_instr * 40);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		seed = 32'h5754_b6e8;
		in_req = 1'b0;
		in_instr = '0;
		in_pc = '0;
		sink_hold = 1'b0;
		sink_delay = 0;
		pc_cur = '0;
		for (int k = 0; k < 32; k++)
			mregs[k] = '0;
		rst = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_alu();
		test_forward();
		test_branch();
		test_zero();
		test_backpressure();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== source/cpu_core.sv ====
// ####################
// cpu_core
// execute core top level: input receiver, decode, register file,
// execute and result sender
// ####################
`timescale 1ns/1ps

module cpu_core #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic in_req,
	input cpu_pkg::instr_t in_instr,
	input cpu_pkg::word_t in_pc,
	output logic in_ack,
	output logic res_req,
	input logic res_ack,
	output logic res_wen,
	output cpu_pkg::reg_addr_t res_waddr,
	output cpu_pkg::word_t res_wdata,
	output logic res_taken,
	output cpu_pkg::word_t res_target
);
	import cpu_pkg::*;

	logic q_valid;
	instr_t q_instr;
	word_t q_pc;
	logic pop;
	logic room;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	word_t ra_data;
	word_t rb_data;
	logic id_valid;
	logic id_c_rfw;
	wbsrc_t id_c_wbsource;
	logic [5:0] id_c_alufunc;
	logic id_c_rfbse;
	logic id_c_b;
	logic id_c_bne;
	logic id_c_j;
	logic id_c_jjr;
	word_t id_rfa;
	word_t id_rfb;
	word_t id_se;
	logic [4:0] id_shamt;
	reg_addr_t id_rs;
	reg_addr_t id_rt;
	reg_addr_t id_rf_waddr;
	word_t id_pc;
	logic [25:0] id_jaddr;
	logic p_valid;
	logic p_c_rfw;
	reg_addr_t p_rf_waddr;
	word_t p_wdata;
	logic p_taken;
	word_t p_target;
	logic wb_rfw;
	reg_addr_t wb_waddr;
	word_t wb_wdata;

	cpu_instr_rx #(.queue_depth(queue_depth)) rx_i (
		.clk(clk), .rst(rst),
		.in_req(in_req), .in_instr(in_instr), .in_pc(in_pc), .in_ack(in_ack),
		.pop(pop), .q_valid(q_valid), .q_instr(q_instr), .q_pc(q_pc)
	);

	cpu_id id_i (
		.clk(clk), .rst(rst),
		.q_valid(q_valid), .q_instr(q_instr), .q_pc(q_pc), .room(room), .pop(pop),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .ra_data(ra_data), .rb_data(rb_data),
		.id_valid(id_valid), .id_c_rfw(id_c_rfw), .id_c_wbsource(id_c_wbsource),
		.id_c_alufunc(id_c_alufunc), .id_c_rfbse(id_c_rfbse), .id_c_b(id_c_b),
		.id_c_bne(id_c_bne), .id_c_j(id_c_j), .id_c_jjr(id_c_jjr),
		.id_rfa(id_rfa), .id_rfb(id_rfb), .id_se(id_se), .id_shamt(id_shamt),
		.id_rs(id_rs), .id_rt(id_rt), .id_rf_waddr(id_rf_waddr),
		.id_pc(id_pc), .id_jaddr(id_jaddr)
	);

	cpu_regfile rf_i (
		.clk(clk), .rst(rst),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .ra_data(ra_data), .rb_data(rb_data),
		.wb_rfw(wb_rfw), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
	);

	cpu_ex ex_i (
		.clk(clk), .rst(rst),
		.id_valid(id_valid), .id_c_rfw(id_c_rfw), .id_c_wbsource(id_c_wbsource),
		.id_c_alufunc(id_c_alufunc), .id_c_rfbse(id_c_rfbse), .id_c_b(id_c_b),
		.id_c_bne(id_c_bne), .id_c_j(id_c_j), .id_c_jjr(id_c_jjr),
		.id_rfa(id_rfa), .id_rfb(id_rfb), .id_se(id_se), .id_shamt(id_shamt),
		.id_rs(id_rs), .id_rt(id_rt), .id_rf_waddr(id_rf_waddr),
		.id_pc(id_pc), .id_jaddr(id_jaddr),
		.wb_rfw(wb_rfw), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
		.p_valid(p_valid), .p_c_rfw(p_c_rfw), .p_rf_waddr(p_rf_waddr),
		.p_wdata(p_wdata), .p_taken(p_taken), .p_target(p_target)
	);

	cpu_result_tx #(.queue_depth(queue_depth)) tx_i (
		.clk(clk), .rst(rst),
		.p_valid(p_valid), .p_c_rfw(p_c_rfw), .p_rf_waddr(p_rf_waddr),
		.p_wdata(p_wdata), .p_taken(p_taken), .p_target(p_target),
		.issue(pop), .room(room),
		.wb_rfw(wb_rfw), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
		.res_req(res_req), .res_ack(res_ack), .res_wen(res_wen),
		.res_waddr(res_waddr), .res_wdata(res_wdata),
		.res_taken(res_taken), .res_target(res_target)
	);

endmodule

// ==== source/cpu_ex.sv ====
// ####################
// cpu_ex
// execute stage: operand forwarding from the p and wb registers, the ALU,
// branch and jump resolution and the execute-to-writeback register
// ####################
`timescale 1ns/1ps

module cpu_ex (
	input logic clk,
	input logic rst,
	input logic id_valid,
	input logic id_c_rfw,
	input cpu_pkg::wbsrc_t id_c_wbsource,
	input logic [5:0] id_c_alufunc,
	input logic id_c_rfbse,
	input logic id_c_b,
	input logic id_c_bne,
	input logic id_c_j,
	input logic id_c_jjr,
	input cpu_pkg::word_t id_rfa,
	input cpu_pkg::word_t id_rfb,
	input cpu_pkg::word_t id_se,
	input logic [4:0] id_shamt,
	input cpu_pkg::reg_addr_t id_rs,
	input cpu_pkg::reg_addr_t id_rt,
	input cpu_pkg::reg_addr_t id_rf_waddr,
	input cpu_pkg::word_t id_pc,
	input logic [25:0] id_jaddr,
	input logic wb_rfw,
	input cpu_pkg::reg_addr_t wb_waddr,
	input cpu_pkg::word_t wb_wdata,
	output logic p_valid,
	output logic p_c_rfw,
	output cpu_pkg::reg_addr_t p_rf_waddr,
	output cpu_pkg::word_t p_wdata,
	output logic p_taken,
	output cpu_pkg::word_t p_target
);
	import cpu_pkg::*;

	word_t x;
	word_t eff_y;
	word_t y;
	word_t alu_r;
	word_t pc_4;
	word_t br_target;
	word_t j_target;
	word_t target;
	logic cond;
	logic taken;

	// the younger result in p wins over wb, register 0 is never forwarded
	always_comb begin
		if (p_c_rfw && (p_rf_waddr == id_rs) && (id_rs != 5'd0))
			x = p_wdata;
		else if (wb_rfw && (wb_waddr == id_rs) && (id_rs != 5'd0))
			x = wb_wdata;
		else
			x = id_rfa;
		if (p_c_rfw && (p_rf_waddr == id_rt) && (id_rt != 5'd0))
			eff_y = p_wdata;
		else if (wb_rfw && (wb_waddr == id_rt) && (id_rt != 5'd0))
			eff_y = wb_wdata;
		else
			eff_y = id_rfb;
	end

	assign y = id_c_rfbse ? id_se : eff_y;

	always_comb begin
		case (id_c_alufunc)
			fn_addu: alu_r = x + y;
			fn_subu: alu_r = x - y;
			fn_and: alu_r = x & y;
			fn_or: alu_r = x | y;
			fn_nor: alu_r = ~(x | y);
			fn_slt: alu_r = {31'd0, $signed(x) < $signed(y)};
			fn_sltu: alu_r = {31'd0, x < y};
			fn_sll: alu_r = y << id_shamt;
			fn_srl: alu_r = y >> id_shamt;
			default: alu_r = '0;
		endcase
	end

	assign pc_4 = id_pc + 32'd4;
	assign br_target = pc_4 + {id_se[29:0], 2'b00};
	assign j_target = {pc_4[31:28], id_jaddr, 2'b00};
	assign cond = id_c_bne ? (alu_r != '0) : (alu_r == '0);
	assign taken = id_c_j || (id_c_b && cond);

	always_comb begin
		if (!taken)
			target = '0;
		else if (id_c_jjr)
			target = x;
		else if (id_c_j)
			target = j_target;
		else
			target = br_target;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			p_valid <= 1'b0;
			p_c_rfw <= 1'b0;
			p_taken <= 1'b0;
		end else begin
			p_valid <= id_valid;
			p_c_rfw <= id_c_rfw;
			p_taken <= taken;
		end
	end

	always_ff @(posedge clk) begin
		p_rf_waddr <= id_rf_waddr;
		p_wdata <= (id_c_wbsource == wb_link) ? id_pc + 32'd8 : alu_r;
		p_target <= target;
	end

endmodule

// ==== source/cpu_id.sv ====
// ####################
// cpu_id
// issue control and instruction decode, registered into the id stage
// ####################
`timescale 1ns/1ps

module cpu_id (
	input logic clk,
	input logic rst,
	input logic q_valid,
	input cpu_pkg::instr_t q_instr,
	input cpu_pkg::word_t q_pc,
	input logic room,
	output logic pop,
	output cpu_pkg::reg_addr_t ra_addr,
	output cpu_pkg::reg_addr_t rb_addr,
	input cpu_pkg::word_t ra_data,
	input cpu_pkg::word_t rb_data,
	output logic id_valid,
	output logic id_c_rfw,
	output cpu_pkg::wbsrc_t id_c_wbsource,
	output logic [5:0] id_c_alufunc,
	output logic id_c_rfbse,
	output logic id_c_b,
	output logic id_c_bne,
	output logic id_c_j,
	output logic id_c_jjr,
	output cpu_pkg::word_t id_rfa,
	output cpu_pkg::word_t id_rfb,
	output cpu_pkg::word_t id_se,
	output logic [4:0] id_shamt,
	output cpu_pkg::reg_addr_t id_rs,
	output cpu_pkg::reg_addr_t id_rt,
	output cpu_pkg::reg_addr_t id_rf_waddr,
	output cpu_pkg::word_t id_pc,
	output logic [25:0] id_jaddr
);
	import cpu_pkg::*;

	logic issue;
	logic d_writes;
	wbsrc_t d_wbsource;
	logic [5:0] d_alufunc;
	logic d_rfbse;
	logic d_b;
	logic d_bne;
	logic d_j;
	logic d_jjr;
	logic d_zext;
	reg_addr_t d_waddr;
	logic [4:0] d_shamt;
	word_t d_se;

	assign issue = q_valid && room;
	assign pop = issue;
	assign ra_addr = q_instr.r.rs;
	assign rb_addr = q_instr.r.rt;
	assign d_se = d_zext ? {16'h0000, q_instr.i.imm} : {{16{q_instr.i.imm[15]}}, q_instr.i.imm};

	always_comb begin
		d_writes = 1'b0;
		d_wbsource = wb_alu;
		d_alufunc = fn_addu;
		d_rfbse = 1'b0;
		d_b = 1'b0;
		d_bne = 1'b0;
		d_j = 1'b0;
		d_jjr = 1'b0;
		d_zext = 1'b0;
		d_waddr = q_instr.i.rt;
		d_shamt = q_instr.r.shamt;
		case (q_instr.r.op)
			op_special: begin
				d_alufunc = q_instr.r.funct;
				d_waddr = q_instr.r.rd;
				case (q_instr.r.funct)
					fn_jr: begin
						d_j = 1'b1;
						d_jjr = 1'b1;
					end
					fn_sll, fn_srl, fn_addu, fn_subu, fn_and, fn_or, fn_nor, fn_slt, fn_sltu:
						d_writes = 1'b1;
					default: d_writes = 1'b0;
				endcase
			end
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_lui: begin
				d_writes = 1'b1;
				d_rfbse = 1'b1;
				case (q_instr.r.op)
					op_slti: d_alufunc = fn_slt;
					op_sltiu: d_alufunc = fn_sltu;
					op_andi: d_alufunc = fn_and;
					op_ori: d_alufunc = fn_or;
					op_lui: d_alufunc = fn_sll;
					default: d_alufunc = fn_addu;
				endcase
				d_zext = (q_instr.r.op == op_andi) || (q_instr.r.op == op_ori);
				if (q_instr.r.op == op_lui)
					d_shamt = 5'd16;
			end
			op_beq, op_bne: begin
				// the branch condition is read from the difference of the operands
				d_alufunc = fn_subu;
				d_b = 1'b1;
				d_bne = (q_instr.r.op == op_bne);
			end
			op_j: d_j = 1'b1;
			op_jal: begin
				d_j = 1'b1;
				d_writes = 1'b1;
				d_wbsource = wb_link;
				d_waddr = 5'd31;
			end
			default: d_writes = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
			id_c_rfw <= 1'b0;
			id_c_b <= 1'b0;
			id_c_bne <= 1'b0;
			id_c_j <= 1'b0;
			id_c_jjr <= 1'b0;
		end else begin
			id_valid <= issue;
			id_c_rfw <= issue && d_writes && (d_waddr != 5'd0);
			id_c_b <= issue && d_b;
			id_c_bne <= issue && d_bne;
			id_c_j <= issue && d_j;
			id_c_jjr <= issue && d_jjr;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			id_c_wbsource <= d_wbsource;
			id_c_alufunc <= d_alufunc;
			id_c_rfbse <= d_rfbse;
			id_rfa <= ra_data;
			id_rfb <= rb_data;
			id_se <= d_se;
			id_shamt <= d_shamt;
			id_rs <= q_instr.r.rs;
			id_rt <= q_instr.r.rt;
			id_rf_waddr <= d_waddr;
			id_pc <= q_pc;
			id_jaddr <= q_instr.j.target;
		end
	end

endmodule

// ==== source/cpu_instr_rx.sv ====
// ####################
// cpu_instr_rx
// four-phase receiver for instruction and pc pairs, backed by a small
// circular queue that feeds the decode stage
// ####################
`timescale 1ns/1ps

module cpu_instr_rx #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic in_req,
	input cpu_pkg::instr_t in_instr,
	input cpu_pkg::word_t in_pc,
	output logic in_ack,
	input logic pop,
	output logic q_valid,
	output cpu_pkg::instr_t q_instr,
	output cpu_pkg::word_t q_pc
);
	import cpu_pkg::*;

	localparam int ptr_w = $clog2(queue_depth);
	localparam int cnt_w = $clog2(queue_depth + 1);

	instr_t mem_instr [queue_depth];
	word_t mem_pc [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic push;

	// a pair is taken on the same edge that raises in_ack, so each handshake pushes once
	assign push = in_req && !in_ack && (count != cnt_w'(queue_depth));

	assign q_valid = (count != '0);
	assign q_instr = mem_instr[rd_ptr];
	assign q_pc = mem_pc[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			in_ack <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0;
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (!push && pop)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_instr[wr_ptr] <= in_instr;
			mem_pc[wr_ptr] <= in_pc;
		end
	end

endmodule

// ==== source/cpu_pkg.sv ====
// ####################
// cpu_pkg
// shared types and encodings for the execute core: the instruction word views,
// opcode and function codes, and the writeback source select
// ####################
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// one instruction word seen as register, immediate or jump format
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0] op;
			logic [25:0] target;
		} j;
	} instr_t;

	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti = 6'h0a;
	localparam logic [5:0] op_sltiu = 6'h0b;
	localparam logic [5:0] op_andi = 6'h0c;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_jr = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_nor = 6'h27;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	typedef enum logic {
		wb_alu = 1'b0,
		wb_link = 1'b1
	} wbsrc_t;

endpackage

// ==== source/cpu_regfile.sv ====
// ####################
// cpu_regfile
// 32 word register file, two read ports and one write port,
// register 0 reads as zero and a same-cycle write is seen by the reads
// ####################
`timescale 1ns/1ps

module cpu_regfile (
	input logic clk,
	input logic rst,
	input cpu_pkg::reg_addr_t ra_addr,
	input cpu_pkg::reg_addr_t rb_addr,
	output cpu_pkg::word_t ra_data,
	output cpu_pkg::word_t rb_data,
	input logic wb_rfw,
	input cpu_pkg::reg_addr_t wb_waddr,
	input cpu_pkg::word_t wb_wdata
);
	import cpu_pkg::*;

	word_t regs [32];

	// write-through closes the gap for a reader three instructions behind the writer
	assign ra_data = (ra_addr == 5'd0) ? '0 :
			(wb_rfw && (wb_waddr == ra_addr)) ? wb_wdata : regs[ra_addr];
	assign rb_data = (rb_addr == 5'd0) ? '0 :
			(wb_rfw && (wb_waddr == rb_addr)) ? wb_wdata : regs[rb_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < 32; k++)
				regs[k] <= '0;
		end else if (wb_rfw && (wb_waddr != 5'd0)) begin
			regs[wb_waddr] <= wb_wdata;
		end
	end

endmodule

// ==== source/cpu_result_tx.sv ====
// ####################
// cpu_result_tx
// writeback register, result queue and four-phase sender; a credit count
// of free result slots limits issue so the pipeline never has to stall
// ####################
`timescale 1ns/1ps

module cpu_result_tx #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic p_valid,
	input logic p_c_rfw,
	input cpu_pkg::reg_addr_t p_rf_waddr,
	input cpu_pkg::word_t p_wdata,
	input logic p_taken,
	input cpu_pkg::word_t p_target,
	input logic issue,
	output logic room,
	output logic wb_rfw,
	output cpu_pkg::reg_addr_t wb_waddr,
	output cpu_pkg::word_t wb_wdata,
	output logic res_req,
	input logic res_ack,
	output logic res_wen,
	output cpu_pkg::reg_addr_t res_waddr,
	output cpu_pkg::word_t res_wdata,
	output logic res_taken,
	output cpu_pkg::word_t res_target
);
	import cpu_pkg::*;

	localparam int ptr_w = $clog2(queue_depth);
	localparam int cnt_w = $clog2(queue_depth + 1);

	logic wb_valid;
	logic wb_taken;
	word_t wb_target;
	logic q_wen [queue_depth];
	reg_addr_t q_waddr [queue_depth];
	word_t q_wdata [queue_depth];
	logic q_taken [queue_depth];
	word_t q_target [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] credits;
	logic pop;

	assign pop = res_req && res_ack;
	assign room = (credits != '0);
	assign res_wen = q_wen[rd_ptr];
	assign res_waddr = q_waddr[rd_ptr];
	assign res_wdata = q_wdata[rd_ptr];
	assign res_taken = q_taken[rd_ptr];
	assign res_target = q_target[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_rfw <= 1'b0;
			res_req <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= cnt_w'(queue_depth);
		end else begin
			wb_valid <= p_valid;
			wb_rfw <= p_c_rfw;
			if (pop)
				res_req <= 1'b0;
			else if (!res_req && !res_ack && (count != '0))
				res_req <= 1'b1;
			if (wb_valid)
				wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (wb_valid && !pop)
				count <= count + 1'b1;
			else if (!wb_valid && pop)
				count <= count - 1'b1;
			// a slot is claimed at issue and given back once the sink takes the record
			if (issue && !pop)
				credits <= credits - 1'b1;
			else if (!issue && pop)
				credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		wb_waddr <= p_rf_waddr;
		wb_wdata <= p_wdata;
		wb_taken <= p_taken;
		wb_target <= p_target;
		if (wb_valid) begin
			q_wen[wr_ptr] <= wb_rfw;
			q_waddr[wr_ptr] <= wb_waddr;
			q_wdata[wr_ptr] <= wb_wdata;
			q_taken[wr_ptr] <= wb_taken;
			q_target[wr_ptr] <= wb_target;
		end
	end

endmodule
